//--- common/mmu_bus_pkg.sv
`include "mmu_consts.svh"

package mmu_bus_pkg;

    // ----------------------------------------------
    // load/store unit side
    // ----------------------------------------------
    typedef struct packed {
        logic            valid;
        sv32_pkg::vaddr_t vaddr;
        logic            is_store;
    } lsu_req_t;

    typedef struct packed {
        logic                valid;
        sv32_pkg::paddr_t    paddr;
        sv32_pkg::exception_t exception;
    } lsu_rsp_t;

    // csr state seen by the mmu
    typedef struct packed {
        logic                en_translation;
        sv32_pkg::priv_lvl_t priv;
        logic                sum;
        sv32_pkg::ppn_t      satp_ppn;
    } csr_ctrl_t;

    // refill from the walker into the tlb
    typedef struct packed {
        logic           valid;
        logic           is_4m;
        sv32_pkg::vpn_t vpn;
        sv32_pkg::pte_t pte;
    } tlb_update_t;

    // ----------------------------------------------
    // apb master port, read only
    // ----------------------------------------------
    typedef struct packed {
        logic             psel;
        logic             penable;
        sv32_pkg::paddr_t paddr;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_L1_REQ,
        PTW_L1_WAIT,
        PTW_L0_REQ,
        PTW_L0_WAIT
    } ptw_state_t;

endpackage

//--- common/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// address and page number widths for Sv32
`define MMU_VLEN          32
`define MMU_PLEN          34
`define MMU_PPNW          22
`define MMU_PAGE_OFFSET_W 12

// vpn split: two 10-bit levels above the page offset
`define MMU_VPN_W         10
`define MMU_VPN0_LSB      12
`define MMU_VPN1_LSB      22

// data tlb depth
`define MMU_DTLB_ENTRIES  4

// mcause codes raised by the mmu
`define MMU_CAUSE_LD_ACCESS 5
`define MMU_CAUSE_ST_ACCESS 7
`define MMU_CAUSE_LD_PAGE   13
`define MMU_CAUSE_ST_PAGE   15

`endif

//--- common/sv32_pkg.sv
`include "mmu_consts.svh"

package sv32_pkg;

    // ----------------------------------------------
    // addresses and page numbers
    // ----------------------------------------------
    typedef logic [`MMU_VLEN-1:0] vaddr_t;
    typedef logic [`MMU_PLEN-1:0] paddr_t;
    typedef logic [`MMU_PPNW-1:0] ppn_t;
    typedef logic [`MMU_VLEN-`MMU_PAGE_OFFSET_W-1:0] vpn_t;

    // sv32 page table entry, msb first
    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // only U and S modes reach the data mmu
    typedef enum logic {
        PRIV_LVL_U = 1'b0,
        PRIV_LVL_S = 1'b1
    } priv_lvl_t;

    typedef enum logic [4:0] {
        EXC_LD_ACCESS = 5'd`MMU_CAUSE_LD_ACCESS,
        EXC_ST_ACCESS = 5'd`MMU_CAUSE_ST_ACCESS,
        EXC_LD_PAGE   = 5'd`MMU_CAUSE_LD_PAGE,
        EXC_ST_PAGE   = 5'd`MMU_CAUSE_ST_PAGE
    } exc_cause_t;

    // tval is always the faulting virtual address
    typedef struct packed {
        exc_cause_t cause;
        vaddr_t     tval;
        logic       valid;
    } exception_t;

endpackage

//--- logic/dtlb.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module dtlb #(
    parameter int unsigned ENTRIES = `MMU_DTLB_ENTRIES
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  sv32_pkg::vpn_t           lookup_vpn_i,
    output logic                     hit_o,
    output sv32_pkg::pte_t           pte_o,
    output logic                     is_4m_o,
    input  mmu_bus_pkg::tlb_update_t update_i
);
    import sv32_pkg::*;
    import mmu_bus_pkg::*;

    localparam int unsigned IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] is_4m_q;
    vpn_t               tag_q [ENTRIES];
    pte_t               pte_q [ENTRIES];
    logic [IDX_W-1:0]   repl_ptr_q;
    logic [ENTRIES-1:0] match;

    // ----------------------------------------------
    // lookup
    // ----------------------------------------------
    // megapages only compare vpn[1]
    always_comb begin
        hit_o   = 1'b0;
        pte_o   = '0;
        is_4m_o = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (tag_q[i][`MMU_VPN_W +: `MMU_VPN_W] == lookup_vpn_i[`MMU_VPN_W +: `MMU_VPN_W])
                && (is_4m_q[i]
                    || (tag_q[i][`MMU_VPN_W-1:0] == lookup_vpn_i[`MMU_VPN_W-1:0]));
            // matches are one-hot, so an or-mux is enough
            if (match[i]) begin
                hit_o   = 1'b1;
                pte_o   = pte_o | pte_q[i];
                is_4m_o = is_4m_o | is_4m_q[i];
            end
        end
    end

    // ----------------------------------------------
    // valid bits and replacement pointer
    // ----------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            repl_ptr_q <= '0;
        end else if (flush_i) begin
            // whole-tlb flush wins over a refill
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[repl_ptr_q] <= 1'b1;
            // round robin over all slots
            if (repl_ptr_q == IDX_W'(ENTRIES - 1)) begin
                repl_ptr_q <= '0;
            end else begin
                repl_ptr_q <= repl_ptr_q + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (update_i.valid && !flush_i) begin
            tag_q[repl_ptr_q]   <= update_i.vpn;
            pte_q[repl_ptr_q]   <= update_i.pte;
            is_4m_q[repl_ptr_q] <= update_i.is_4m;
        end
    end

    // refill only follows a miss, so no page is ever cached twice
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(match))
        else $error("dtlb: more than one entry hits");

endmodule

//--- logic/lsu_translate.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module lsu_translate (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  mmu_bus_pkg::csr_ctrl_t     csr_i,
    input  mmu_bus_pkg::lsu_req_t      lsu_req_i,
    output logic                       lsu_ready_o,
    output mmu_bus_pkg::lsu_rsp_t      lsu_rsp_o,
    output sv32_pkg::vpn_t             lookup_vpn_o,
    input  logic                       tlb_hit_i,
    input  sv32_pkg::pte_t             tlb_pte_i,
    input  logic                       tlb_is_4m_i,
    output logic                       walk_req_o,
    output sv32_pkg::vpn_t             walk_vpn_o,
    output logic                       walk_is_store_o,
    input  logic                       walk_done_i,
    input  sv32_pkg::exc_cause_t       walk_fault_i,
    input  logic                       walk_fault_valid_i
);
    import sv32_pkg::*;
    import mmu_bus_pkg::*;

    logic   req_valid_q;
    vaddr_t vaddr_q;
    logic   is_store_q;
    logic   perm_err;
    logic   walk_fault;
    logic   rsp_fire;

    // ----------------------------------------------
    // request stage
    // ----------------------------------------------
    // accept when empty or when the held request leaves this cycle
    assign lsu_ready_o = !req_valid_q || rsp_fire;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_valid_q <= 1'b0;
        end else if (lsu_ready_o) begin
            req_valid_q <= lsu_req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lsu_ready_o && lsu_req_i.valid) begin
            vaddr_q    <= lsu_req_i.vaddr;
            is_store_q <= lsu_req_i.is_store;
        end
    end

    // tlb lookup and walk request from the held address
    assign lookup_vpn_o    = vaddr_q[`MMU_VLEN-1:`MMU_PAGE_OFFSET_W];
    assign walk_vpn_o      = vaddr_q[`MMU_VLEN-1:`MMU_PAGE_OFFSET_W];
    assign walk_is_store_o = is_store_q;
    assign walk_req_o      = req_valid_q && csr_i.en_translation && !tlb_hit_i;

    // ----------------------------------------------
    // permission checks on a hit
    // ----------------------------------------------
    always_comb begin
        perm_err = 1'b0;
        // user page rules, sum lets S touch U pages
        if (csr_i.priv == PRIV_LVL_U && !tlb_pte_i.u) perm_err = 1'b1;
        if (csr_i.priv == PRIV_LVL_S && tlb_pte_i.u && !csr_i.sum) perm_err = 1'b1;
        // no hardware a/d update, missing bits fault
        if (!tlb_pte_i.a) perm_err = 1'b1;
        if (is_store_q && (!tlb_pte_i.w || !tlb_pte_i.d)) perm_err = 1'b1;
        if (!is_store_q && !tlb_pte_i.r) perm_err = 1'b1;
    end

    assign walk_fault = walk_done_i && walk_fault_valid_i;
    assign rsp_fire   = req_valid_q && (!csr_i.en_translation || tlb_hit_i || walk_fault);

    // ----------------------------------------------
    // response
    // ----------------------------------------------
    always_comb begin
        lsu_rsp_o.valid     = rsp_fire;
        lsu_rsp_o.paddr     = {{(`MMU_PLEN-`MMU_VLEN){1'b0}}, vaddr_q};
        lsu_rsp_o.exception = '{cause: EXC_LD_PAGE, tval: vaddr_q, valid: 1'b0};
        if (csr_i.en_translation) begin
            // 4k page: ppn then offset
            lsu_rsp_o.paddr = {tlb_pte_i.ppn, vaddr_q[`MMU_PAGE_OFFSET_W-1:0]};
            // megapage: vpn[0] stands in for ppn[0]
            if (tlb_is_4m_i) begin
                lsu_rsp_o.paddr[`MMU_VPN1_LSB-1:`MMU_VPN0_LSB] =
                    vaddr_q[`MMU_VPN1_LSB-1:`MMU_VPN0_LSB];
            end
            if (walk_fault) begin
                lsu_rsp_o.exception.cause = walk_fault_i;
                lsu_rsp_o.exception.valid = req_valid_q;
            end else if (tlb_hit_i && perm_err) begin
                lsu_rsp_o.exception.cause = is_store_q ? EXC_ST_PAGE : EXC_LD_PAGE;
                lsu_rsp_o.exception.valid = req_valid_q;
            end
        end
    end

    // a walk result only comes back while the missing request is still held
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        walk_done_i |-> walk_req_o)
        else $error("lsu_translate: walk result with no walk requested");

endmodule

//--- logic/mmu_sv32.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_sv32 (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  mmu_bus_pkg::csr_ctrl_t csr_i,
    input  mmu_bus_pkg::lsu_req_t  lsu_req_i,
    output logic                   lsu_ready_o,
    output mmu_bus_pkg::lsu_rsp_t  lsu_rsp_o,
    output mmu_bus_pkg::apb_req_t  apb_req_o,
    input  mmu_bus_pkg::apb_rsp_t  apb_rsp_i
);
    import sv32_pkg::*;
    import mmu_bus_pkg::*;

    // stage <-> tlb
    vpn_t        lookup_vpn;
    logic        tlb_hit;
    pte_t        tlb_pte;
    logic        tlb_is_4m;
    // stage <-> walker
    logic        walk_req;
    vpn_t        walk_vpn;
    logic        walk_is_store;
    logic        walk_done;
    exc_cause_t  walk_fault;
    logic        walk_fault_valid;
    // walker -> tlb refill
    tlb_update_t tlb_update;

    lsu_translate u_lsu_translate (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .csr_i              (csr_i),
        .lsu_req_i          (lsu_req_i),
        .lsu_ready_o        (lsu_ready_o),
        .lsu_rsp_o          (lsu_rsp_o),
        .lookup_vpn_o       (lookup_vpn),
        .tlb_hit_i          (tlb_hit),
        .tlb_pte_i          (tlb_pte),
        .tlb_is_4m_i        (tlb_is_4m),
        .walk_req_o         (walk_req),
        .walk_vpn_o         (walk_vpn),
        .walk_is_store_o    (walk_is_store),
        .walk_done_i        (walk_done),
        .walk_fault_i       (walk_fault),
        .walk_fault_valid_i (walk_fault_valid)
    );

    dtlb #(
        .ENTRIES (`MMU_DTLB_ENTRIES)
    ) u_dtlb (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .lookup_vpn_i (lookup_vpn),
        .hit_o        (tlb_hit),
        .pte_o        (tlb_pte),
        .is_4m_o      (tlb_is_4m),
        .update_i     (tlb_update)
    );

    ptw u_ptw (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .satp_ppn_i         (csr_i.satp_ppn),
        .walk_req_i         (walk_req),
        .walk_vpn_i         (walk_vpn),
        .walk_done_o        (walk_done),
        .walk_fault_o       (walk_fault),
        .walk_fault_valid_o (walk_fault_valid),
        .is_store_i         (walk_is_store),
        .update_o           (tlb_update),
        .apb_req_o          (apb_req_o),
        .apb_rsp_i          (apb_rsp_i)
    );

endmodule

//--- project.f
+incdir+common
common/sv32_pkg.sv
common/mmu_bus_pkg.sv
logic/dtlb.sv
ptw/ptw.sv
logic/lsu_translate.sv
logic/mmu_sv32.sv
test/tb_clock_gen.sv
test/tb_mmu_sv32.sv

//--- ptw/ptw.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module ptw (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  sv32_pkg::ppn_t           satp_ppn_i,
    input  logic                     walk_req_i,
    input  sv32_pkg::vpn_t           walk_vpn_i,
    output logic                     walk_done_o,
    output sv32_pkg::exc_cause_t     walk_fault_o,
    output logic                     walk_fault_valid_o,
    input  logic                     is_store_i,
    output mmu_bus_pkg::tlb_update_t update_o,
    output mmu_bus_pkg::apb_req_t    apb_req_o,
    input  mmu_bus_pkg::apb_rsp_t    apb_rsp_i
);
    import sv32_pkg::*;
    import mmu_bus_pkg::*;

    ptw_state_t state_q;
    ptw_state_t state_d;
    paddr_t     paddr_q;
    paddr_t     paddr_d;
    pte_t       pte;
    logic       done;
    logic       page_fault;
    logic       access_fault;
    logic       pte_bad;
    logic       pte_leaf;

    assign pte      = pte_t'(apb_rsp_i.prdata);
    // invalid, or write without read (reserved encoding)
    assign pte_bad  = !pte.v || (pte.w && !pte.r);
    assign pte_leaf = pte.r || pte.x;

    // ----------------------------------------------
    // walk fsm
    // ----------------------------------------------
    always_comb begin
        state_d      = state_q;
        paddr_d      = paddr_q;
        done         = 1'b0;
        page_fault   = 1'b0;
        access_fault = 1'b0;
        case (state_q)
            PTW_IDLE: begin
                // level 1 pte at satp.ppn * 4k + vpn[1] * 4
                if (walk_req_i) begin
                    paddr_d = {satp_ppn_i, walk_vpn_i[`MMU_VPN_W +: `MMU_VPN_W], 2'b00};
                    state_d = PTW_L1_REQ;
                end
            end
            PTW_L1_REQ: state_d = PTW_L1_WAIT;
            PTW_L1_WAIT: begin
                if (apb_rsp_i.pready) begin
                    done = 1'b1;
                    if (apb_rsp_i.pslverr) begin
                        access_fault = 1'b1;
                    end else if (pte_bad) begin
                        page_fault = 1'b1;
                    end else if (pte_leaf) begin
                        // megapage must be aligned to 4M
                        page_fault = (pte.ppn[`MMU_VPN_W-1:0] != '0);
                    end else begin
                        // pointer to the next level
                        done    = 1'b0;
                        paddr_d = {pte.ppn, walk_vpn_i[`MMU_VPN_W-1:0], 2'b00};
                        state_d = PTW_L0_REQ;
                    end
                    if (done) begin
                        state_d = PTW_IDLE;
                    end
                end
            end
            PTW_L0_REQ: state_d = PTW_L0_WAIT;
            PTW_L0_WAIT: begin
                if (apb_rsp_i.pready) begin
                    done    = 1'b1;
                    state_d = PTW_IDLE;
                    if (apb_rsp_i.pslverr) begin
                        access_fault = 1'b1;
                    end else begin
                        // no further level after 0
                        page_fault = pte_bad || !pte_leaf;
                    end
                end
            end
            default: state_d = PTW_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= PTW_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        paddr_q <= paddr_d;
    end

    // ----------------------------------------------
    // outputs
    // ----------------------------------------------
    // setup in *_REQ, access in *_WAIT
    assign apb_req_o.psel    = (state_q != PTW_IDLE);
    assign apb_req_o.penable = (state_q == PTW_L1_WAIT) || (state_q == PTW_L0_WAIT);
    assign apb_req_o.paddr   = paddr_q;

    assign walk_done_o        = done;
    assign walk_fault_valid_o = page_fault || access_fault;
    assign walk_fault_o       = access_fault ? (is_store_i ? EXC_ST_ACCESS : EXC_LD_ACCESS)
                                             : (is_store_i ? EXC_ST_PAGE : EXC_LD_PAGE);

    // leaf goes into the tlb as read, stage checks the flags
    assign update_o.valid = done && !page_fault && !access_fault;
    assign update_o.is_4m = (state_q == PTW_L1_WAIT);
    assign update_o.vpn   = walk_vpn_i;
    assign update_o.pte   = pte;

    // apb rule: request held until the slave answers
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        apb_req_o.penable && !apb_rsp_i.pready |=> $stable(apb_req_o))
        else $error("ptw: apb request changed during access phase");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the mmu testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_mmu_sv32 \
    -Mdir obj_dir

output="$(./obj_dir/Vtb_mmu_sv32)"
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS   = 8.0,
    parameter int  RST_CYCLES  = 10
) (
    output logic clk_o,
    output logic rst_no
);
    // free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // reset held low for a fixed number of cycles
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

//--- test/tb_mmu_sv32.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module tb_mmu_sv32;
    import sv32_pkg::*;
    import mmu_bus_pkg::*;

    localparam int N_PHASE = 4;
    localparam int N_PER   = 60;
    localparam int N_REQ   = N_PHASE * N_PER;
    localparam int N_POOL  = 10;

    logic clk_i;
    logic rst_ni;
    logic flush_i;
    csr_ctrl_t csr;
    lsu_req_t  lsu_req;
    logic      lsu_ready;
    lsu_rsp_t  lsu_rsp;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;

    int seed = 32'h6224_d82b;
    int err_paddr;
    int err_exc;
    int err_count;
    int err_other;
    int cyc;
    int apb_reads;
    int last_reads;
    int wait_left;

    // apb memory image and slave-error addresses
    logic [31:0] mem [paddr_t];
    bit          err_addr [paddr_t];

    // model tlb
    logic       m_valid [4];
    logic       m_4m    [4];
    vpn_t       m_vpn   [4];
    pte_t       m_pte   [4];
    int         m_ptr;

    // expected responses in acceptance order
    paddr_t     exp_paddr_q [$];
    exception_t exp_exc_q   [$];
    int         exp_reads_q [$];
    int         acc_cyc_q   [$];

    vaddr_t     pool [N_POOL];

    tb_clock_gen u_clk (.clk_o(clk_i), .rst_no(rst_ni));

    mmu_sv32 u_mmu_sv32 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .csr_i       (csr),
        .lsu_req_i   (lsu_req),
        .lsu_ready_o (lsu_ready),
        .lsu_rsp_o   (lsu_rsp),
        .apb_req_o   (apb_req),
        .apb_rsp_i   (apb_rsp)
    );

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic compare_paddr(string name, paddr_t exp, paddr_t act);
        if (exp !== act) begin
            $display("error t=%0t %s expected %h actual %h", $time, name, exp, act);
            err_paddr++;
        end
    endtask

    task automatic compare_exc(string name, exception_t exp, exception_t act);
        if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
            $display("error t=%0t %s expected %h actual %h", $time, name, exp, act);
            err_exc++;
        end
    endtask

    task automatic compare_count(string name, int exp, int act);
        if (exp != act) begin
            $display("error t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    function automatic int rnd(int n);
        return {$random(seed)} % n;
    endfunction

    // random leaf, reserved w-without-r avoided
    function automatic pte_t make_leaf(ppn_t ppn);
        pte_t p;
        p = '0;
        p.ppn = ppn;
        p.v = 1'b1;
        p.r = (rnd(2) != 0);
        p.w = (rnd(2) != 0);
        p.x = (rnd(2) != 0);
        p.u = (rnd(2) != 0);
        p.a = (rnd(4) != 0);
        p.d = (rnd(4) != 0);
        if (p.w && !p.r) p.r = 1'b1;
        if (!p.r && !p.x) p.x = 1'b1;
        return p;
    endfunction

    // page tables: root at satp, vpn1 0..7, level 0 tables at ppn 0x100+i
    task automatic build_tables();
        paddr_t a;
        pte_t   p;
        int     k;
        for (int i = 0; i < 8; i++) begin
            a = {csr.satp_ppn, 10'(i), 2'b00};
            k = rnd(8);
            p = '0;
            if (k < 4) begin
                p.v = 1'b1;
                p.ppn = 22'h100 + 22'(i);
                for (int j = 0; j < 8; j++) begin
                    int kk;
                    pte_t q;
                    paddr_t b;
                    b = {p.ppn, 10'(j), 2'b00};
                    kk = rnd(8);
                    q = make_leaf(22'($random(seed)));
                    if (kk == 5) q.v = 1'b0;
                    if (kk == 6) begin
                        q.r = 1'b0;
                        q.w = 1'b0;
                        q.x = 1'b0;
                    end
                    if (kk == 7) err_addr[b] = 1'b1;
                    mem[b] = q;
                end
            end else if (k == 4) begin
                p = make_leaf({12'($random(seed)), 10'd0});
            end else if (k == 5) begin
                // megapage that is not 4M aligned
                p = make_leaf({12'($random(seed)), 10'd3});
            end else if (k == 6) begin
                p.v = (rnd(2) != 0);
                p.w = 1'b1;
            end else begin
                err_addr[a] = 1'b1;
            end
            mem[a] = p;
        end
    endtask

    function automatic logic [31:0] mem_rd(paddr_t a);
        return mem.exists(a) ? mem[a] : 32'h0;
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic perm_fault(pte_t p, logic st);
        if (csr.priv == PRIV_LVL_U && !p.u) return 1'b1;
        if (csr.priv == PRIV_LVL_S && p.u && !csr.sum) return 1'b1;
        if (!p.a) return 1'b1;
        if (st && (!p.w || !p.d)) return 1'b1;
        if (!st && !p.r) return 1'b1;
        return 1'b0;
    endfunction

    task automatic predict(vaddr_t va, logic st, output paddr_t pa,
                           output exception_t ex, output int reads);
        vpn_t   vpn;
        pte_t   p;
        logic   is4m;
        logic   hit;
        paddr_t a;
        vpn = va[31:12];
        reads = 0;
        hit = 1'b0;
        is4m = 1'b0;
        p = '0;
        ex = '{cause: EXC_LD_PAGE, tval: va, valid: 1'b0};
        pa = {2'b00, va};
        if (!csr.en_translation) return;
        for (int i = 0; i < 4; i++) begin
            if (m_valid[i] && m_vpn[i][19:10] == vpn[19:10]
                && (m_4m[i] || m_vpn[i][9:0] == vpn[9:0])) begin
                hit = 1'b1;
                p = m_pte[i];
                is4m = m_4m[i];
            end
        end
        if (!hit) begin
            a = {csr.satp_ppn, vpn[19:10], 2'b00};
            reads = 1;
            ex.cause = st ? EXC_ST_PAGE : EXC_LD_PAGE;
            if (err_addr.exists(a)) begin
                ex.cause = st ? EXC_ST_ACCESS : EXC_LD_ACCESS;
                ex.valid = 1'b1;
                return;
            end
            p = pte_t'(mem_rd(a));
            if (!p.v || (p.w && !p.r)) begin
                ex.valid = 1'b1;
                return;
            end
            if (p.r || p.x) begin
                is4m = 1'b1;
                if (p.ppn[9:0] != 0) begin
                    ex.valid = 1'b1;
                    return;
                end
            end else begin
                a = {p.ppn, vpn[9:0], 2'b00};
                reads = 2;
                if (err_addr.exists(a)) begin
                    ex.cause = st ? EXC_ST_ACCESS : EXC_LD_ACCESS;
                    ex.valid = 1'b1;
                    return;
                end
                p = pte_t'(mem_rd(a));
                if (!p.v || (p.w && !p.r) || !(p.r || p.x)) begin
                    ex.valid = 1'b1;
                    return;
                end
            end
            // refill in round-robin order
            m_valid[m_ptr] = 1'b1;
            m_vpn[m_ptr] = vpn;
            m_pte[m_ptr] = p;
            m_4m[m_ptr] = is4m;
            m_ptr = (m_ptr + 1) % 4;
        end
        pa = {p.ppn, va[11:0]};
        if (is4m) pa[21:12] = va[21:12];
        if (perm_fault(p, st)) begin
            ex.cause = st ? EXC_ST_PAGE : EXC_LD_PAGE;
            ex.valid = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // apb slave with random wait states
    // --------------------------------------------------
    // a finished transfer drops pready, the next setup phase may follow at once
    always @(posedge clk_i) begin
        #1;
        if (apb_rsp.pready) begin
            apb_rsp = '0;
        end
        if (apb_req.psel && !apb_req.penable) begin
            wait_left = rnd(4);
        end else if (apb_req.psel && apb_req.penable) begin
            if (wait_left == 0) begin
                apb_rsp.pready = 1'b1;
                apb_rsp.pslverr = (err_addr.exists(apb_req.paddr) != 0);
                apb_rsp.prdata = mem_rd(apb_req.paddr);
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk_i) cyc++;

    // monitor: apb reads, responses, then new acceptances
    always @(negedge clk_i) begin
        if (rst_ni) begin
            paddr_t     pa;
            exception_t ex;
            int         rd;
            if (apb_req.psel && apb_req.penable && apb_rsp.pready) apb_reads++;
            if (lsu_rsp.valid) begin
                if (exp_paddr_q.size() == 0) begin
                    $display("response arrived with no request outstanding at t=%0t", $time);
                    err_other++;
                end else begin
                    pa = exp_paddr_q.pop_front();
                    ex = exp_exc_q.pop_front();
                    rd = exp_reads_q.pop_front();
                    compare_exc("lsu_rsp.exception", ex, lsu_rsp.exception);
                    if (!ex.valid) compare_paddr("lsu_rsp.paddr", pa, lsu_rsp.paddr);
                    compare_count("apb_reads", rd, apb_reads - last_reads);
                    if (rd == 0) compare_count("rsp_latency", 1, cyc - acc_cyc_q[0]);
                    void'(acc_cyc_q.pop_front());
                    last_reads = apb_reads;
                end
            end
            if (lsu_req.valid && lsu_ready) begin
                predict(lsu_req.vaddr, lsu_req.is_store, pa, ex, rd);
                exp_paddr_q.push_back(pa);
                exp_exc_q.push_back(ex);
                exp_reads_q.push_back(rd);
                acc_cyc_q.push_back(cyc);
            end
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic issue_req(vaddr_t va, logic st);
        lsu_req = '{valid: 1'b1, vaddr: va, is_store: st};
        forever begin
            @(negedge clk_i);
            if (lsu_ready) break;
        end
        step();
        lsu_req.valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_paddr_q.size() != 0) step();
        step();
    endtask

    task automatic flush_tlb();
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        for (int i = 0; i < 4; i++) m_valid[i] = 1'b0;
    endtask

    initial begin
        flush_i = 1'b0;
        lsu_req = '0;
        apb_rsp = '0;
        csr = '{en_translation: 1'b0, priv: PRIV_LVL_S, sum: 1'b0, satp_ppn: 22'h40};
        m_ptr = 0;
        for (int i = 0; i < 4; i++) m_valid[i] = 1'b0;
        build_tables();
        for (int i = 0; i < N_POOL; i++) begin
            pool[i] = {10'(rnd(8)), 10'(rnd(8)), 12'h0};
        end
        @(posedge rst_ni);
        step();
        if (!lsu_ready || lsu_rsp.valid || apb_req.psel) begin
            $display("outputs after reset are not idle");
            err_other++;
        end
        for (int ph = 0; ph < N_PHASE; ph++) begin
            wait_idle();
            csr.en_translation = (ph != 0);
            csr.priv = (ph == 3) ? PRIV_LVL_U : PRIV_LVL_S;
            csr.sum = (ph == 2);
            flush_tlb();
            for (int n = 0; n < N_PER; n++) begin
                vaddr_t va;
                va = pool[rnd(N_POOL)] | 32'(rnd(4096));
                // occasional address far outside the mapped tables
                if (rnd(10) == 0) va = $random(seed);
                issue_req(va, (rnd(2) != 0));
                repeat (rnd(3)) step();
                if (n == N_PER / 2) begin
                    wait_idle();
                    flush_tlb();
                end
            end
        end
        wait_idle();
        repeat (5) step();
        $display("errors: paddr=%0d exc=%0d count=%0d other=%0d",
                 err_paddr, err_exc, err_count, err_other);
        if (err_paddr + err_exc + err_count + err_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog sized from the request count
    initial begin
        #(N_REQ * 40 * 8);
        $display("timeout: simulation did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule
